// File: hw/matrix_pkg.sv
package matrix_pkg;

    ////////////////////
    // panel geometry
    ////////////////////

    localparam int ROWS = 8;
    localparam int COLS = 8;

    typedef logic [$clog2(ROWS)-1:0] row_idx_t;   // row 0 is the top row

    // one row of lit dots, bit 7 is the leftmost column
    typedef logic [COLS-1:0] col_bits_t;

    ////////////////////
    // color planes
    ////////////////////

    // yellow lights both the red and the green plane
    typedef enum logic [1:0]
    {
        HUE_OFF    = 2'd0,
        HUE_RED    = 2'd1,
        HUE_GREEN  = 2'd2,
        HUE_YELLOW = 2'd3
    } hue_t;

endpackage

// File: hw/count_pkg.sv
package count_pkg;

    // 0 is blank, 1 to 5 are drawn
    typedef logic [2:0] digit_t;

    localparam digit_t START_DIGIT = 3'd5;   // first digit shown
    localparam digit_t END_DIGIT   = 3'd1;   // last digit before done

endpackage

// File: hw/glyph_if.sv
`timescale 1ns/1ps

interface glyph_if;

    matrix_pkg::row_idx_t  row_index;   // row being looked up
    count_pkg::digit_t     digit;       // digit on display
    matrix_pkg::col_bits_t colr;        // red plane for that row
    matrix_pkg::col_bits_t colg;        // green plane for that row

    modport scanner
    (
        output row_index,
        output digit,
        input  colr,
        input  colg
    );

    modport renderer
    (
        input  row_index,
        input  digit,
        output colr,
        output colg
    );

endinterface

// File: hw/tick_divider.sv
`timescale 1ns/1ps

module tick_divider
#(
    parameter int DIV = 4
)
(
    input  logic clk,
    input  logic rst,
    input  logic en,
    output logic tick
);

    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (!en)
            cnt <= '0;   // fresh phase for every run
        else if (cnt == LAST)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // high in the last cycle of each period
    assign tick = en && (cnt == LAST);

endmodule

// File: hw/countdown_ctrl.sv
`timescale 1ns/1ps

module countdown_ctrl
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start_req,
    input  logic              step_tick,
    output logic              start_ack,
    output logic              busy,
    output count_pkg::digit_t digit
);

    typedef enum logic [1:0]
    {
        ST_IDLE  = 2'd0,
        ST_COUNT = 2'd1,
        ST_DONE  = 2'd2
    } state_t;

    state_t state;

    ////////////////////
    // handshake and countdown
    ////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= ST_IDLE;
            start_ack <= 1'b0;
            busy      <= 1'b0;
            digit     <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start_req)
                    begin
                        state <= ST_COUNT;
                        busy  <= 1'b1;
                        digit <= count_pkg::START_DIGIT;
                    end
                end
                ST_COUNT:
                begin
                    if (step_tick)
                    begin
                        if (digit == count_pkg::END_DIGIT)
                        begin
                            state     <= ST_DONE;
                            busy      <= 1'b0;
                            start_ack <= 1'b1;   // countdown finished
                            digit     <= '0;
                        end
                        else
                            digit <= digit - 1'b1;
                    end
                end
                ST_DONE:
                begin
                    if (!start_req)   // wait for req to drop
                    begin
                        state     <= ST_IDLE;
                        start_ack <= 1'b0;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/row_scanner.sv
`timescale 1ns/1ps

module row_scanner
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  busy,
    input  logic                  row_tick,
    input  count_pkg::digit_t     digit,
    glyph_if.scanner              glyph,
    output matrix_pkg::col_bits_t row,
    output matrix_pkg::col_bits_t colr,
    output matrix_pkg::col_bits_t colg
);

    // select line for row 0 sits on bit 7
    localparam matrix_pkg::col_bits_t ROW0_SEL = {1'b1, {(matrix_pkg::COLS-1){1'b0}}};
    localparam matrix_pkg::row_idx_t  LAST_ROW = matrix_pkg::row_idx_t'(matrix_pkg::ROWS - 1);

    matrix_pkg::row_idx_t row_idx;

    assign glyph.row_index = row_idx;
    assign glyph.digit     = digit;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= '0;
            row     <= '0;
            colr    <= '0;
            colg    <= '0;
        end
        else if (!busy)
        begin
            row_idx <= '0;   // panel dark when idle
            row     <= '0;
            colr    <= '0;
            colg    <= '0;
        end
        else if (row_tick)
        begin
            row_idx <= (row_idx == LAST_ROW) ? '0 : row_idx + 1'b1;
            row     <= ROW0_SEL >> row_idx;   // select and pattern move together
            colr    <= glyph.colr;
            colg    <= glyph.colg;
        end
    end

endmodule

// File: hw/digit_glyph.sv
`timescale 1ns/1ps

module digit_glyph
(
    glyph_if.renderer glyph
);

    matrix_pkg::col_bits_t bitmap;
    matrix_pkg::hue_t      hue;

    ////////////////////
    // glyph table
    ////////////////////

    // row 0 stays blank in every glyph
    always_comb
    begin
        bitmap = '0;
        case (glyph.digit)
            3'd5:
                case (glyph.row_index)
                    3'd1:       bitmap = 8'b0111_1110;
                    3'd2:       bitmap = 8'b0110_0000;
                    3'd3:       bitmap = 8'b0111_1100;
                    3'd4, 3'd5: bitmap = 8'b0000_0110;
                    3'd6:       bitmap = 8'b0110_0110;
                    3'd7:       bitmap = 8'b0011_1100;
                    default:    bitmap = '0;
                endcase
            3'd4:
                case (glyph.row_index)
                    3'd1:       bitmap = 8'b0000_1100;
                    3'd2:       bitmap = 8'b0001_1100;
                    3'd3:       bitmap = 8'b0010_1100;
                    3'd4:       bitmap = 8'b0100_1100;
                    3'd5:       bitmap = 8'b0111_1110;
                    3'd6, 3'd7: bitmap = 8'b0000_1100;
                    default:    bitmap = '0;
                endcase
            3'd3:
                case (glyph.row_index)
                    3'd1, 3'd7: bitmap = 8'b0011_1100;
                    3'd2, 3'd6: bitmap = 8'b0110_0110;
                    3'd3, 3'd5: bitmap = 8'b0000_0110;
                    3'd4:       bitmap = 8'b0001_1100;
                    default:    bitmap = '0;
                endcase
            3'd2:
                case (glyph.row_index)
                    3'd1:       bitmap = 8'b0011_1100;
                    3'd2:       bitmap = 8'b0110_0110;
                    3'd3:       bitmap = 8'b0000_0110;
                    3'd4:       bitmap = 8'b0000_1100;
                    3'd5:       bitmap = 8'b0011_0000;
                    3'd6:       bitmap = 8'b0110_0000;
                    3'd7:       bitmap = 8'b0111_1110;
                    default:    bitmap = '0;
                endcase
            3'd1:
                case (glyph.row_index)
                    3'd3:       bitmap = 8'b0011_1000;   // flag of the one
                    3'd7:       bitmap = 8'b0111_1110;   // base
                    3'd0:       bitmap = '0;
                    default:    bitmap = 8'b0001_1000;
                endcase
            default:
                bitmap = '0;   // 0 and unused codes are blank
        endcase
    end

    ////////////////////
    // color rule
    ////////////////////

    always_comb
    begin
        case (glyph.digit)
            3'd5, 3'd4: hue = matrix_pkg::HUE_RED;
            3'd3, 3'd2: hue = matrix_pkg::HUE_YELLOW;
            3'd1:       hue = matrix_pkg::HUE_GREEN;
            default:    hue = matrix_pkg::HUE_OFF;
        endcase
    end

    // yellow drives both planes with the same pattern
    assign glyph.colr = (hue == matrix_pkg::HUE_RED || hue == matrix_pkg::HUE_YELLOW)
                        ? bitmap : '0;
    assign glyph.colg = (hue == matrix_pkg::HUE_GREEN || hue == matrix_pkg::HUE_YELLOW)
                        ? bitmap : '0;

endmodule

// File: hw/countdown_display.sv
`timescale 1ns/1ps

module countdown_display
#(
    parameter int ROW_DIV  = 4,    // cycles per row
    parameter int STEP_DIV = 64    // cycles per digit
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_req,
    output logic                  start_ack,
    output matrix_pkg::col_bits_t row,
    output matrix_pkg::col_bits_t colr,
    output matrix_pkg::col_bits_t colg
);

    logic              busy;
    logic              row_tick;
    logic              step_tick;
    count_pkg::digit_t digit;

    glyph_if glyph ();

    countdown_ctrl u_ctrl
    (
        .clk       (clk),
        .rst       (rst),
        .start_req (start_req),
        .step_tick (step_tick),
        .start_ack (start_ack),
        .busy      (busy),
        .digit     (digit)
    );

    ////////////////////
    // timing
    ////////////////////

    tick_divider #(.DIV(ROW_DIV)) row_div
    (
        .clk  (clk),
        .rst  (rst),
        .en   (busy),
        .tick (row_tick)
    );

    tick_divider #(.DIV(STEP_DIV)) step_div
    (
        .clk  (clk),
        .rst  (rst),
        .en   (busy),
        .tick (step_tick)
    );

    ////////////////////
    // panel drive
    ////////////////////

    row_scanner u_scanner
    (
        .clk      (clk),
        .rst      (rst),
        .busy     (busy),
        .row_tick (row_tick),
        .digit    (digit),
        .glyph    (glyph.scanner),
        .row      (row),
        .colr     (colr),
        .colg     (colg)
    );

    digit_glyph u_glyph
    (
        .glyph (glyph.renderer)
    );

endmodule

// File: sim/tb_countdown_display.sv
`timescale 1ns/1ps

module tb_countdown_display;

    localparam int ROW_DIV   = 4;
    localparam int STEP_DIV  = 64;
    localparam int NUM_RUNS  = 6;
    localparam int MAX_GAP   = 16;                          // 4 random bits per gap
    localparam int ACK_AFTER = 5 * STEP_DIV + 1;
    localparam int WATCHDOG  = NUM_RUNS * (5 * STEP_DIV + MAX_GAP + 8) + 100;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  start_req;
    logic                  start_ack;
    matrix_pkg::col_bits_t row;
    matrix_pkg::col_bits_t colr;
    matrix_pkg::col_bits_t colg;

    int          cycle     = 0;
    int          req_cycle = 0;                             // cycle count when req was driven
    int          done_cnt  = 0;
    int          fails [6] = '{default: 0};
    string       test_name [6] = '{"reset_idle", "row_scan", "glyph_content",
                                   "color_rule", "handshake", "back_to_back"};
    logic [7:0]  row_q;
    logic        ack_q;
    logic        req_q;
    logic [4:0]  seen;                                      // digits drawn this run
    logic [31:0] lfsr = 32'hef03;
    int          since;
    int          shown;
    logic [7:0]  exp_r;
    logic [7:0]  exp_g;
    logic        new_row;

    always #10 clk = ~clk;

    countdown_display #(.ROW_DIV(ROW_DIV), .STEP_DIV(STEP_DIV)) DUT
    (
        .clk       (clk),
        .rst       (rst),
        .start_req (start_req),
        .start_ack (start_ack),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

    ////////////////////
    // reference model
    ////////////////////

    function automatic logic [7:0] ref_bitmap(input int d, input int r);
        logic [63:0] g;                                     // row 0 in the top byte
        case (d)
            5:       g = 64'h007e_607c_0606_663c;
            4:       g = 64'h000c_1c2c_4c7e_0c0c;
            3:       g = 64'h003c_6606_1c06_663c;
            2:       g = 64'h003c_6606_0c30_607e;
            1:       g = 64'h0018_1838_1818_187e;
            default: g = '0;
        endcase
        return 8'(g >> (8 * (7 - r)));
    endfunction

    function automatic bit ref_red(input int d);
        return d >= 2 && d <= 5;
    endfunction

    function automatic bit ref_green(input int d);
        return d >= 1 && d <= 3;
    endfunction

    // digit that was latched with the row seen at this sample
    function automatic int shown_digit(input int cycles);
        return 5 - (cycles - 3) / STEP_DIV;
    endfunction

    function automatic int row_number(input logic [7:0] sel);
        int r;
        r = 0;
        for (int i = 0; i < 8; i++)
            if (sel == (8'h80 >> i))
                r = i;
        return r;
    endfunction

    function automatic logic [7:0] plane_for(input logic [7:0] sel, input int d, input bit lit);
        return lit ? ref_bitmap(d, row_number(sel)) : 8'h00;
    endfunction

    function automatic logic [7:0] next_row(input logic [7:0] prev);
        return (prev == '0) ? 8'h80 : {prev[0], prev[7:1]};   // bit 7 follows bit 0
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic record_fail(input int t, input int expected, input int actual);
        fails[t] = fails[t] + 1;
        $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", test_name[t], expected, actual);
    endtask

    assign since   = cycle - req_cycle;
    assign shown   = shown_digit(since);
    assign exp_r   = plane_for(row, shown, ref_red(shown));
    assign exp_g   = plane_for(row, shown, ref_green(shown));
    assign new_row = row != '0 && row != row_q;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        row_q <= row;
        ack_q <= start_ack;
        req_q <= start_req;
        if (rst || start_ack)
            seen <= '0;
        else if (new_row && (colr | colg) != '0 && colr == exp_r && colg == exp_g)
            seen <= seen | 5'(1 << (shown - 1));
        if (start_ack && !ack_q)
            done_cnt <= done_cnt + 1;
    end

    ////////////////////
    // checks
    ////////////////////

    a_idle: assert property (@(posedge clk) disable iff (rst)
        !start_req || ack_q |-> (row | colr | colg) == '0 && (!start_ack || req_q))
    else
        record_fail(0, 0, 32'({$sampled(start_ack), $sampled(row), $sampled(colr),
                               $sampled(colg)}));

    a_scan: assert property (@(posedge clk) disable iff (rst)
        row != row_q |-> row == '0 || row == next_row(row_q))
    else
        record_fail(1, 32'(next_row($sampled(row_q))), 32'($sampled(row)));

    a_glyph: assert property (@(posedge clk) disable iff (rst)
        new_row |-> colr == exp_r && colg == exp_g)
    else
        record_fail(2, 32'({$sampled(exp_r), $sampled(exp_g)}),
                    32'({$sampled(colr), $sampled(colg)}));

    a_color: assert property (@(posedge clk) disable iff (rst)
        new_row |-> (colr == '0 || ref_red(shown)) && (colg == '0 || ref_green(shown))
                    && (colr == '0 || colg == '0 || colr == colg))
    else
        record_fail(3, $sampled(shown), 32'({$sampled(colr), $sampled(colg)}));

    a_ack_time: assert property (@(posedge clk) disable iff (rst)
        $rose(start_ack) |-> since - 1 == ACK_AFTER)
    else
        record_fail(4, ACK_AFTER, $sampled(since) - 1);

    a_ack_hold: assert property (@(posedge clk) disable iff (rst)
        ack_q && req_q |-> start_ack)
    else
        record_fail(4, 1, 32'($sampled(start_ack)));

    a_req_rule: assert property (@(posedge clk) disable iff (rst)
        $rose(start_req) |-> !start_ack)
    else
        record_fail(5, 0, 32'($sampled(start_ack)));

    a_full_seq: assert property (@(posedge clk) disable iff (rst)
        $rose(start_ack) |-> seen == 5'h1f)
    else
        record_fail(5, 32'h1f, 32'($sampled(seen)));

    ////////////////////
    // stimulus
    ////////////////////

    initial
    begin
        int gap;
        int passed;
        passed    = 0;
        rst       = 1'b1;
        start_req = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NUM_RUNS; n++)
        begin
            take_bits(4, gap);
            repeat (gap + 1) @(posedge clk);
            start_req <= 1'b1;
            req_cycle = cycle;
            @(posedge clk);
            while (!start_ack)
                @(posedge clk);                             // countdown running
            start_req <= 1'b0;
            @(posedge clk);
            while (start_ack)
                @(posedge clk);
        end
        repeat (4) @(posedge clk);
        assert (done_cnt == NUM_RUNS)
        else
            record_fail(5, NUM_RUNS, done_cnt);
        for (int t = 0; t < 6; t++)
        begin
            $display("test %-14s %s", test_name[t], (fails[t] == 0) ? "passed" : "failed");
            if (fails[t] == 0)
                passed++;
        end
        $display("tests 6, passed %0d, failed %0d, countdowns %0d", passed, 6 - passed, done_cnt);
        if (passed == 6)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles, countdowns did not complete", WATCHDOG);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: sim.f
hw/matrix_pkg.sv
hw/count_pkg.sv
hw/glyph_if.sv
hw/tick_divider.sv
hw/countdown_ctrl.sv
hw/row_scanner.sv
hw/digit_glyph.sv
hw/countdown_display.sv
sim/tb_countdown_display.sv

// File: Makefile
TOOL     = verilator
TOP      = tb_countdown_display
FILELIST = sim.f
FLAGS    = --timing --assert
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the log holds the pass line
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
